//--- tb_vgpr_wb.sv
`timescale 1ns/1ns

module tb_vgpr_wb;

  import vgpr_geom_pkg::*;
  import vgpr_port_pkg::*;

  logic           clk = 1'b0;
  logic           rst_n;
  port_en_arr_t   port_wr_en;
  port_mask_arr_t port_wr_mask;
  port_addr_arr_t port_wr_addr;
  port_data_arr_t port_wr_data;
  logic           rd_en;
  vgpr_addr_t     rd_addr;
  vreg_t          rd_data;
  logic           collision;

  logic [31:0] rng_state = 32'd80141;                    // Data generator state
  int          timeout_count = 0;
  int          err_total;

  vgpr_wb_top vgpr_wb_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .port_wr_en   (port_wr_en),
    .port_wr_mask (port_wr_mask),
    .port_wr_addr (port_wr_addr),
    .port_wr_data (port_wr_data),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .collision    (collision)
  );

  initial
  begin
    forever #2 clk = ~clk;                               // 4 ns period
  end

  // ##################################################
  // Helpers
  // ##################################################

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic tick();
    @(negedge clk);                                      // Inputs change away from the rising edge
  endtask

  task automatic clear_ports();
    port_wr_en   = '0;
    port_wr_mask = '0;
    port_wr_addr = '0;
    port_wr_data = '0;
  endtask

  task automatic put_write(input int p, input reg_en_t en, input lane_mask_t mask,
                           input vgpr_addr_t addr);
    wr_data_t d;
    for (int w = 0; w < $bits(wr_data_t) / 32; w++)
    begin
      rng_state = xorshift(rng_state);
      d[w*32 +: 32] = rng_state;
    end
    port_wr_en[p]   = en;
    port_wr_mask[p] = mask;
    port_wr_addr[p] = addr;
    port_wr_data[p] = d;
  endtask

  // Back-to-back reads whose results the checker compares one cycle later
  task automatic read_range(input vgpr_addr_t first, input int count);
    rd_en = 1'b1;
    for (int k = 0; k < count; k++)
    begin
      rd_addr = first + vgpr_addr_t'(k);
      tick();
    end
    rd_en = 1'b0;
    tick();
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    rd_en = 1'b0;
    clear_ports();
    repeat (4) tick();
    rst_n = 1'b1;
  endtask

  task automatic wait_collision(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (collision !== level && n < limit)
    begin
      tick();
      n++;
    end
    if (collision !== level)
    begin
      timeout_count++;
      $display("TIMEOUT: collision did not %s within %0d cycles", what, limit);
    end
  endtask

  // ##################################################
  // Stimulus
  // ##################################################

  initial
  begin
    rst_n   = 1'b0;
    rd_en   = 1'b0;
    rd_addr = '0;
    clear_ports();
    apply_reset();
    wait_collision(1'b0, 4, "clear after reset");
    read_range(0, reg_count);                            // Whole file reads zero

    // Every port writes one register with a single enable bit
    for (int p = 0; p < port_count; p++)
    begin
      put_write(p, (p % 2) ? 2'b10 : 2'b01, 4'hF, vgpr_addr_t'(p * 5 + 1));
      tick();
      clear_ports();
      tick();
      read_range(vgpr_addr_t'(p * 5 + 1 + p % 2), 1);
    end

    put_write(4, 2'b11, 4'hF, 6'd20);                    // Base and next register
    tick();
    clear_ports();
    tick();
    read_range(6'd20, 2);
    put_write(7, 2'b11, 4'hF, 6'd63);                    // Second half wraps to register 0
    tick();
    clear_ports();
    tick();
    read_range(6'd63, 2);

    // Partial masks over registers that already hold data
    put_write(2, 2'b01, 4'b0101, 6'd20);
    tick();
    clear_ports();
    put_write(8, 2'b10, 4'b0010, 6'd62);
    tick();
    clear_ports();
    tick();
    read_range(6'd20, 2);
    read_range(6'd63, 1);

    for (int p = 0; p < port_count; p++)
    begin
      clear_ports();
      put_write(p, 2'b01, 4'hF, vgpr_addr_t'(40 + p));  // A new port every cycle
      tick();
    end
    clear_ports();
    tick();
    read_range(6'd40, port_count);

    // Port 3 should win over port 6 when both write in one cycle
    put_write(3, 2'b01, 4'hF, 6'd50);
    put_write(6, 2'b01, 4'hF, 6'd52);
    tick();
    clear_ports();
    wait_collision(1'b1, 4, "rise after a two-port write");
    tick();
    read_range(6'd50, 3);
    repeat (8) tick();                                   // Flag must hold

    apply_reset();
    wait_collision(1'b0, 4, "clear after the second reset");
    read_range(6'd50, 3);

    err_total = vgpr_wb_top_inst.wb_checks_inst.err_count + timeout_count;
    $display("Errors: %0d assertion failures, %0d timeouts",
             vgpr_wb_top_inst.wb_checks_inst.err_count, timeout_count);
    if (err_total == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- vgpr_bank.sv
`timescale 1ns/1ns

module vgpr_bank (
  input  logic                      clk,
  input  logic                      rst_n,
  vgpr_wr_if.snk                    wr,
  input  logic                      rd_en,
  input  vgpr_geom_pkg::vgpr_addr_t rd_addr,
  output vgpr_geom_pkg::vreg_t      rd_data
);

  import vgpr_geom_pkg::*;

  vreg_t      regs [reg_count];                          // The register file
  vgpr_addr_t tgt_addr [regs_per_write];                 // Register hit by each enable bit
  vreg_t      wr_half [regs_per_write];                  // Data for each target register
  vreg_t      rd_q;

  // ##################################################
  // Write decode
  // ##################################################

  always_comb
  begin
    for (int i = 0; i < regs_per_write; i++)
    begin
      // Address arithmetic is six bits wide, so 63 + 1 lands on register 0
      tgt_addr[i] = wr.wr_addr + vgpr_addr_t'(i);
      wr_half[i]  = wr.wr_data[i*$bits(vreg_t) +: $bits(vreg_t)];
    end
  end

  // ##################################################
  // Masked commit
  // ##################################################

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int r = 0; r < reg_count; r++)
      begin
        regs[r] <= '0;                                   // File starts out all zero
      end
    end
    else
    begin
      for (int i = 0; i < regs_per_write; i++)
      begin
        if (wr.wr_en[i])
        begin
          for (int l = 0; l < lane_count; l++)
          begin
            if (wr.wr_mask[l])
            begin
              // Unmasked lanes keep their old value
              regs[tgt_addr[i]][l*lane_width +: lane_width] <=
                wr_half[i][l*lane_width +: lane_width];
            end
          end
        end
      end
    end
  end

  // ##################################################
  // Read port
  // ##################################################

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rd_q <= '0;
    end
    else if (rd_en)
    begin
      rd_q <= regs[rd_addr];                             // Sees the content before a same-edge write
    end
  end

  assign rd_data = rd_q;

endmodule

//--- vgpr_geom_pkg.sv
package vgpr_geom_pkg;

  // ##################################################
  // Register file geometry
  // ##################################################

  localparam int lane_count     = 4;                     // Lanes per register
  localparam int lane_width     = 32;                    // Bits per lane
  localparam int reg_count      = 64;                    // Registers in the file
  localparam int regs_per_write = 2;                     // Registers one write can cover
  localparam int addr_width     = $clog2(reg_count);     // Register address bits

  // ##################################################
  // Vector types
  // ##################################################

  typedef logic [addr_width-1:0]           vgpr_addr_t;  // Register address
  typedef logic [lane_count-1:0]           lane_mask_t;  // One bit per lane
  typedef logic [regs_per_write-1:0]       reg_en_t;     // Bit i writes base + i

  // One register with lane 0 in the low bits
  typedef logic [lane_count*lane_width-1:0] vreg_t;

  // Data for two registers; the base register sits in the low half
  typedef logic [regs_per_write*$bits(vreg_t)-1:0] wr_data_t;

endpackage

//--- vgpr_port_pkg.sv
package vgpr_port_pkg;

  // ##################################################
  // Write port fan-in
  // ##################################################

  localparam int port_count = 9;                         // Functional units with a write port

  typedef logic [port_count-1:0] port_sel_t;             // One-hot with bit p selecting port p

  // Per-port bundles indexed by port number
  typedef vgpr_geom_pkg::reg_en_t    [port_count-1:0] port_en_arr_t;
  typedef vgpr_geom_pkg::lane_mask_t [port_count-1:0] port_mask_arr_t;
  typedef vgpr_geom_pkg::vgpr_addr_t [port_count-1:0] port_addr_arr_t;
  typedef vgpr_geom_pkg::wr_data_t   [port_count-1:0] port_data_arr_t;

endpackage

//--- vgpr_wb.f
vgpr_geom_pkg.sv
vgpr_port_pkg.sv
vgpr_wr_if.sv
wb_port_select.sv
wr_port_mux.sv
vgpr_bank.sv
vgpr_wb_top.sv
vgpr_wb_assertions.sv
tb_vgpr_wb.sv

//--- vgpr_wb_assertions.sv
`timescale 1ns/1ns

module vgpr_wb_assertions (
  input logic                          clk,
  input logic                          rst_n,
  input vgpr_port_pkg::port_en_arr_t   port_wr_en,
  input vgpr_port_pkg::port_mask_arr_t port_wr_mask,
  input vgpr_port_pkg::port_addr_arr_t port_wr_addr,
  input vgpr_port_pkg::port_data_arr_t port_wr_data,
  input logic                          rd_en,
  input vgpr_geom_pkg::vgpr_addr_t     rd_addr,
  input vgpr_geom_pkg::vreg_t          rd_data,
  input logic                          collision
);

  import vgpr_geom_pkg::*;
  import vgpr_port_pkg::*;

  int         err_count = 0;                             // Read by the testbench at the end
  vreg_t      shadow [reg_count];                        // Expected register file
  reg_en_t    pend_en;                                   // Winning write from one edge earlier
  lane_mask_t pend_mask;
  vgpr_addr_t pend_addr;
  wr_data_t   pend_data;
  vreg_t      exp_rd;                                    // Expected read result
  logic       exp_coll;                                  // Expected sticky collision

  // ##################################################
  // Reference model of the write path
  // ##################################################

  // Lowest-numbered requesting port wins and any second request sets the flag
  always_ff @(posedge clk)
  begin : pick_winner
    int   req_count;
    logic found;
    if (!rst_n)
    begin
      pend_en  <= '0;
      exp_coll <= 1'b0;
    end
    else
    begin
      req_count = 0;
      found     = 1'b0;
      pend_en  <= '0;
      for (int p = 0; p < port_count; p++)
      begin
        if (|port_wr_en[p])
        begin
          req_count++;
          if (!found)
          begin
            found = 1'b1;
            pend_en   <= port_wr_en[p];
            pend_mask <= port_wr_mask[p];
            pend_addr <= port_wr_addr[p];
            pend_data <= port_wr_data[p];
          end
        end
      end
      if (req_count > 1)
        exp_coll <= 1'b1;
    end
  end

  // Commit one edge after the pick while a read sees the content before that commit
  always_ff @(posedge clk)
  begin : commit_write
    vgpr_addr_t tgt;
    if (!rst_n)
    begin
      for (int r = 0; r < reg_count; r++)
        shadow[r] <= '0;
      exp_rd <= '0;
    end
    else
    begin
      if (rd_en)
        exp_rd <= shadow[rd_addr];
      for (int i = 0; i < regs_per_write; i++)
      begin
        if (pend_en[i])
        begin
          tgt = pend_addr + vgpr_addr_t'(i);             // Wraps at 64
          for (int l = 0; l < lane_count; l++)
          begin
            if (pend_mask[l])
              shadow[tgt][l*lane_width +: lane_width] <=
                pend_data[i*$bits(vreg_t) + l*lane_width +: lane_width];
          end
        end
      end
    end
  end

  // ##################################################
  // Checks
  // ##################################################

  read_back: assert property (@(posedge clk) disable iff (!rst_n) rd_en |=> rd_data == exp_rd)
    else
    begin
      err_count++;
      $error("FAIL read_back expected %h actual %h", $sampled(exp_rd), $sampled(rd_data));
    end

  collision_track: assert property (@(posedge clk) disable iff (!rst_n) collision == exp_coll)
    else
    begin
      err_count++;
      $error("FAIL collision_track expected %b actual %b", $sampled(exp_coll),
             $sampled(collision));
    end

  reset_zero: assert property (@(posedge clk) $rose(rst_n) |-> !collision && rd_data == '0)
    else
    begin
      err_count++;
      $error("FAIL reset_zero expected collision 0 rd_data 0 actual collision %b rd_data %h",
             $sampled(collision), $sampled(rd_data));
    end

endmodule

bind vgpr_wb_top vgpr_wb_assertions wb_checks_inst (.*);

//--- vgpr_wb_top.sv
`timescale 1ns/1ns

module vgpr_wb_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  vgpr_port_pkg::port_en_arr_t   port_wr_en,
  input  vgpr_port_pkg::port_mask_arr_t port_wr_mask,
  input  vgpr_port_pkg::port_addr_arr_t port_wr_addr,
  input  vgpr_port_pkg::port_data_arr_t port_wr_data,
  input  logic                          rd_en,
  input  vgpr_geom_pkg::vgpr_addr_t     rd_addr,
  output vgpr_geom_pkg::vreg_t          rd_data,
  output logic                          collision
);

  import vgpr_port_pkg::*;

  port_sel_t port_sel;                                   // One-hot winner of this cycle

  vgpr_wr_if wr_bus ();                                  // Registered write bus

  // ##################################################
  // Stage 1 picks a port
  // ##################################################

  wb_port_select port_select_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .port_wr_en (port_wr_en),
    .port_sel   (port_sel),
    .collision  (collision)
  );

  // Stage 2 registers the winner onto the bus
  wr_port_mux port_mux_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .port_sel     (port_sel),
    .port_wr_en   (port_wr_en),
    .port_wr_mask (port_wr_mask),
    .port_wr_addr (port_wr_addr),
    .port_wr_data (port_wr_data),
    .wr           (wr_bus.src)
  );

  // ##################################################
  // Stage 3 commits into the register file
  // ##################################################

  vgpr_bank bank_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr_bus.snk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- vgpr_wr_if.sv
`timescale 1ns/1ns

interface vgpr_wr_if;

  import vgpr_geom_pkg::*;

  reg_en_t    wr_en;                                     // Any bit high means a write this cycle
  lane_mask_t wr_mask;                                   // Lanes to update
  vgpr_addr_t wr_addr;                                   // Base register
  wr_data_t   wr_data;                                   // Two registers of data

  // Multiplexer side
  modport src (
    output wr_en,
    output wr_mask,
    output wr_addr,
    output wr_data
  );

  // Register file side
  modport snk (
    input wr_en,
    input wr_mask,
    input wr_addr,
    input wr_data
  );

endinterface

//--- wb_port_select.sv
`timescale 1ns/1ns

module wb_port_select (
  input  logic                       clk,
  input  logic                       rst_n,
  input  vgpr_port_pkg::port_en_arr_t port_wr_en,
  output vgpr_port_pkg::port_sel_t    port_sel,
  output logic                       collision
);

  import vgpr_port_pkg::*;

  port_sel_t req;                                        // One request bit per port
  logic      multi_req;                                  // Two or more ports at once
  logic      collision_q;

  // ##################################################
  // Request reduction and priority pick
  // ##################################################

  always_comb
  begin
    for (int p = 0; p < port_count; p++)
    begin
      req[p] = |port_wr_en[p];                           // Either register enable counts
    end
  end

  // Two's complement isolates the lowest set bit, so port 0 has top priority
  assign port_sel = req & (~req + 1'b1);

  // Clearing the lowest bit leaves something only when a second request exists
  assign multi_req = |(req & (req - 1'b1));

  // ##################################################
  // Sticky collision flag
  // ##################################################

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      collision_q <= 1'b0;
    end
    else if (multi_req)
    begin
      collision_q <= 1'b1;                               // Held until the next reset
    end
  end

  assign collision = collision_q;

endmodule

//--- wr_port_mux.sv
`timescale 1ns/1ns

module wr_port_mux (
  input  logic                          clk,
  input  logic                          rst_n,
  input  vgpr_port_pkg::port_sel_t      port_sel,
  input  vgpr_port_pkg::port_en_arr_t   port_wr_en,
  input  vgpr_port_pkg::port_mask_arr_t port_wr_mask,
  input  vgpr_port_pkg::port_addr_arr_t port_wr_addr,
  input  vgpr_port_pkg::port_data_arr_t port_wr_data,
  vgpr_wr_if.src                        wr
);

  import vgpr_geom_pkg::*;
  import vgpr_port_pkg::*;

  reg_en_t    sel_en;                                    // Fields of the selected port
  lane_mask_t sel_mask;
  vgpr_addr_t sel_addr;
  wr_data_t   sel_data;
  logic       any_sel;

  // ##################################################
  // One-hot AND-OR selection
  // ##################################################

  always_comb
  begin
    sel_en   = '0;
    sel_mask = '0;
    sel_addr = '0;
    sel_data = '0;
    for (int p = 0; p < port_count; p++)
    begin
      if (port_sel[p])
      begin
        sel_en   |= port_wr_en[p];                       // Select is one-hot, so OR acts as a mux
        sel_mask |= port_wr_mask[p];
        sel_addr |= port_wr_addr[p];
        sel_data |= port_wr_data[p];
      end
    end
  end

  assign any_sel = |port_sel;

  // ##################################################
  // Bus register
  // ##################################################

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wr.wr_en <= '0;
    else
      wr.wr_en <= sel_en;                                // Zero when no port is selected
  end

  // Payload only moves when some port is selected, otherwise the last write stays on the bus
  always_ff @(posedge clk)
  begin
    if (any_sel)
    begin
      wr.wr_mask <= sel_mask;
      wr.wr_addr <= sel_addr;
      wr.wr_data <= sel_data;
    end
  end

endmodule
